// File: hw/nn_pkg.sv
`default_nettype none

package nn_pkg;

    ////////////////////////////////////////
    // layer geometry
    ////////////////////////////////////////
    localparam int neuron_num = 4;    // neurons, also max inputs
    localparam int cnt_w      = 3;    // holds 0..neuron_num

    ////////////////////////////////////////
    // fixed point
    ////////////////////////////////////////
    localparam int out_w    = 10;     // neuron output, signed
    localparam int wgt_w    = 16;     // one weight, signed
    localparam int fraction = 0;      // bits dropped after accumulation
    localparam int acc_w    = 30;     // room for neuron_num products

    // saturation limits, accumulator width
    localparam logic signed [acc_w-1:0] out_max = acc_w'((1 << (out_w - 1)) - 1);
    localparam logic signed [acc_w-1:0] out_min = -out_max - 1;

    ////////////////////////////////////////
    // encodings
    ////////////////////////////////////////
    typedef enum logic {
        act_linear = 1'b0,
        act_relu   = 1'b1
    } act_e;

    typedef enum logic [1:0] {
        idle,
        calc,
        done
    } layer_state_e;

    typedef enum logic [1:0] {
        n_idle,
        n_acc,
        n_hold
    } neuron_state_e;

endpackage

`default_nettype wire

// File: hw/neuron.sv
`timescale 1ns/1ps
`default_nettype none

module neuron (
    input  logic                                             clk,
    input  logic                                             rst,
    input  logic                                             start,        // begin a run
    input  logic [nn_pkg::cnt_w-1:0]                         input_number, // inputs in use
    input  logic [nn_pkg::neuron_num-1:0][nn_pkg::out_w-1:0] inputs,
    input  logic [nn_pkg::neuron_num-1:0][nn_pkg::wgt_w-1:0] weights,
    output logic [nn_pkg::out_w-1:0]                         neuron_sum,
    output logic                                             overflow,
    output logic                                             sum_valid,
    input  logic                                             sum_ack
);

    import nn_pkg::*;

    ////////////////////////////////////////
    // registers and wires
    ////////////////////////////////////////
    neuron_state_e                    state;
    logic [cnt_w-1:0]                 idx;     // current input index
    logic [cnt_w-1:0]                 num_r;   // latched input count
    logic [neuron_num-1:0][out_w-1:0] x_r;
    logic [neuron_num-1:0][wgt_w-1:0] w_r;
    logic signed [acc_w-1:0]          acc;
    logic signed [acc_w-1:0]          product;
    logic signed [acc_w-1:0]          scaled;
    logic                             more;    // products still to add
    logic                             load;

    assign load = (state == n_idle) && start;
    assign more = (idx < num_r);

    // one signed product per cycle, zero past the last input
    always_comb begin
        product = '0;
        if (more) begin
            product = $signed(w_r[idx]) * $signed(x_r[idx]);
        end
    end

    assign scaled = acc >>> fraction;

    ////////////////////////////////////////
    // control
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= n_idle;
            idx   <= '0;
        end else begin
            case (state)
                n_idle: begin
                    if (start) begin
                        state <= n_acc;
                        idx   <= '0;
                    end
                end
                n_acc: begin
                    if (more) begin
                        idx <= idx + 1'b1;
                    end else begin
                        state <= n_hold;    // scale and saturate this cycle
                    end
                end
                n_hold: begin
                    if (sum_ack) begin
                        state <= n_idle;
                    end
                end
                default: state <= n_idle;
            endcase
        end
    end

    ////////////////////////////////////////
    // datapath
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (load) begin
            x_r   <= inputs;
            w_r   <= weights;
            num_r <= input_number;
            acc   <= '0;
        end else if (state == n_acc) begin
            if (more) begin
                acc <= acc + product;
            end else if (scaled > out_max) begin
                neuron_sum <= out_max[out_w-1:0];   // clip high
                overflow   <= 1'b1;
            end else if (scaled < out_min) begin
                neuron_sum <= out_min[out_w-1:0];   // clip low
                overflow   <= 1'b1;
            end else begin
                neuron_sum <= scaled[out_w-1:0];
                overflow   <= 1'b0;
            end
        end
    end

    assign sum_valid = (state == n_hold);

endmodule

`default_nettype wire

// File: hw/layer.sv
`timescale 1ns/1ps
`default_nettype none

module layer (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic [nn_pkg::cnt_w-1:0]                   job_curr,   // active neurons
    input  logic [nn_pkg::cnt_w-1:0]                   job_prev,   // inputs per neuron
    input  logic [nn_pkg::neuron_num-1:0][nn_pkg::out_w-1:0] job_inputs,
    input  logic [nn_pkg::neuron_num-1:0][nn_pkg::neuron_num-1:0][nn_pkg::wgt_w-1:0] job_weights,
    input  logic                                       job_valid,
    output logic                                       job_ready,
    output logic [nn_pkg::neuron_num-1:0][nn_pkg::out_w-1:0] lay_outputs,
    output logic                                       lay_overflow,
    output logic                                       lay_valid,
    input  logic                                       lay_ready
);

    import nn_pkg::*;

    ////////////////////////////////////////
    // registers and wires
    ////////////////////////////////////////
    layer_state_e                     state;
    logic [cnt_w-1:0]                 curr_r;   // active count of the running job
    logic                             accept;
    logic                             drain;    // result leaves the layer
    logic                             all_done;
    logic [neuron_num-1:0][out_w-1:0] sums;
    logic [neuron_num-1:0]            ovfs;
    logic [neuron_num-1:0]            dones;
    logic [neuron_num-1:0]            active;

    assign accept   = job_valid && (state == idle);
    assign drain    = lay_valid && lay_ready;
    assign all_done = &dones;

    ////////////////////////////////////////
    // neuron array
    ////////////////////////////////////////
    genvar i;
    generate
        for (i = 0; i < neuron_num; i = i + 1) begin : g_neuron
            neuron neuron_i (
                .clk          (clk),
                .rst          (rst),
                .start        (accept),           // all neurons start together
                .input_number (job_prev),
                .inputs       (job_inputs),
                .weights      (job_weights[i]),
                .neuron_sum   (sums[i]),
                .overflow     (ovfs[i]),
                .sum_valid    (dones[i]),
                .sum_ack      (drain)
            );

            // neurons past the active count read as zero
            assign active[i]      = (cnt_w'(i) < curr_r);
            assign lay_outputs[i] = active[i] ? sums[i] : '0;
        end
    endgenerate

    ////////////////////////////////////////
    // FSM
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= idle;
            curr_r <= '0;
        end else begin
            case (state)
                idle: begin
                    if (accept) begin
                        state  <= calc;
                        curr_r <= job_curr;
                    end
                end
                calc: begin
                    if (all_done) begin
                        state <= done;
                    end
                end
                done: begin
                    // hold result until the output stage takes it
                    if (lay_ready) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    ////////////////////////////////////////
    // outputs
    ////////////////////////////////////////
    assign job_ready    = (state == idle);
    assign lay_valid    = (state == done);
    assign lay_overflow = |(ovfs & active);   // inactive overflow ignored

endmodule

`default_nettype wire

// File: hw/job_loader.sv
`timescale 1ns/1ps
`default_nettype none

module job_loader (
    input  logic                                             clk,
    input  logic                                             rst,
    input  logic [nn_pkg::cnt_w-1:0]                         cfg_curr,
    input  logic [nn_pkg::cnt_w-1:0]                         cfg_prev,
    input  nn_pkg::act_e                                     cfg_act,
    input  logic [nn_pkg::neuron_num-1:0][nn_pkg::out_w-1:0] cfg_inputs,
    input  logic                                             cfg_valid,
    output logic                                             cfg_ready,
    input  logic [nn_pkg::neuron_num-1:0][nn_pkg::wgt_w-1:0] row_data,
    input  logic                                             row_valid,
    output logic                                             row_ready,
    output logic [nn_pkg::cnt_w-1:0]                         job_curr,
    output logic [nn_pkg::cnt_w-1:0]                         job_prev,
    output nn_pkg::act_e                                     job_act,
    output logic [nn_pkg::neuron_num-1:0][nn_pkg::out_w-1:0] job_inputs,
    output logic [nn_pkg::neuron_num-1:0][nn_pkg::neuron_num-1:0][nn_pkg::wgt_w-1:0] job_weights,
    output logic                                             job_valid,
    input  logic                                             job_ready
);

    import nn_pkg::*;

    logic             loading;    // rows still pending
    logic [cnt_w-1:0] row_cnt;    // next row to fill
    logic             cfg_xfer;
    logic             row_xfer;
    logic             job_xfer;
    logic             last_row;

    assign cfg_ready = !loading && !job_valid;
    assign row_ready = loading;
    assign cfg_xfer  = cfg_valid && cfg_ready;
    assign row_xfer  = row_valid && row_ready;
    assign job_xfer  = job_valid && job_ready;
    assign last_row  = (row_cnt + 1'b1 == job_curr);

    ////////////////////////////////////////
    // control
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            loading   <= 1'b0;
            job_valid <= 1'b0;
            row_cnt   <= '0;
        end else if (cfg_xfer) begin
            row_cnt   <= '0;
            loading   <= (cfg_curr != '0);
            job_valid <= (cfg_curr == '0);   // nothing to collect
        end else if (row_xfer) begin
            row_cnt <= row_cnt + 1'b1;
            if (last_row) begin
                loading   <= 1'b0;
                job_valid <= 1'b1;
            end
        end else if (job_xfer) begin
            job_valid <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // job buffer
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (cfg_xfer) begin
            job_curr    <= cfg_curr;
            job_prev    <= cfg_prev;
            job_act     <= cfg_act;
            job_inputs  <= cfg_inputs;
            job_weights <= '0;                  // unused rows stay zero
        end else if (row_xfer) begin
            job_weights[row_cnt] <= row_data;   // row r feeds neuron r
        end
    end

endmodule

`default_nettype wire

// File: hw/activation_out.sv
`timescale 1ns/1ps
`default_nettype none

module activation_out (
    input  logic                                             clk,
    input  logic                                             rst,
    input  nn_pkg::act_e                                     act_sel,
    input  logic                                             act_load,   // layer took a job
    input  logic [nn_pkg::neuron_num-1:0][nn_pkg::out_w-1:0] lay_outputs,
    input  logic                                             lay_overflow,
    input  logic                                             lay_valid,
    output logic                                             lay_ready,
    output logic [nn_pkg::neuron_num-1:0][nn_pkg::out_w-1:0] outputs,
    output logic                                             overflow,
    output logic                                             outputs_valid,
    input  logic                                             outputs_ready
);

    import nn_pkg::*;

    act_e                             act_r;     // opcode of the job in the layer
    logic                             lay_xfer;
    logic [neuron_num-1:0][out_w-1:0] act_vec;

    assign lay_ready = !outputs_valid;          // only into an empty register
    assign lay_xfer  = lay_valid && lay_ready;

    // relu clears negative elements
    always_comb begin
        for (int i = 0; i < neuron_num; i++) begin
            if (act_r == act_relu && lay_outputs[i][out_w-1]) begin
                act_vec[i] = '0;
            end else begin
                act_vec[i] = lay_outputs[i];
            end
        end
    end

    ////////////////////////////////////////
    // control
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            act_r         <= act_linear;
            outputs_valid <= 1'b0;
        end else begin
            if (act_load) begin
                act_r <= act_sel;
            end
            if (lay_xfer) begin
                outputs_valid <= 1'b1;
            end else if (outputs_ready) begin
                outputs_valid <= 1'b0;   // sink took it
            end
        end
    end

    // result register
    always_ff @(posedge clk) begin
        if (lay_xfer) begin
            outputs  <= act_vec;
            overflow <= lay_overflow;    // flag passes unchanged
        end
    end

endmodule

`default_nettype wire

// File: hw/nn_layer_top.sv
`timescale 1ns/1ps
`default_nettype none

module nn_layer_top (
    input  logic                                             clk,
    input  logic                                             rst,
    input  logic [nn_pkg::cnt_w-1:0]                         cfg_curr,
    input  logic [nn_pkg::cnt_w-1:0]                         cfg_prev,
    input  nn_pkg::act_e                                     cfg_act,
    input  logic [nn_pkg::neuron_num-1:0][nn_pkg::out_w-1:0] cfg_inputs,
    input  logic                                             cfg_valid,
    output logic                                             cfg_ready,
    input  logic [nn_pkg::neuron_num-1:0][nn_pkg::wgt_w-1:0] row_data,
    input  logic                                             row_valid,
    output logic                                             row_ready,
    output logic [nn_pkg::neuron_num-1:0][nn_pkg::out_w-1:0] outputs,
    output logic                                             overflow,
    output logic                                             outputs_valid,
    input  logic                                             outputs_ready
);

    import nn_pkg::*;

    ////////////////////////////////////////
    // internal channels
    ////////////////////////////////////////
    logic [cnt_w-1:0]                                job_curr;
    logic [cnt_w-1:0]                                job_prev;
    act_e                                            act_sel;   // bypasses the layer
    logic [neuron_num-1:0][out_w-1:0]                job_inputs;
    logic [neuron_num-1:0][neuron_num-1:0][wgt_w-1:0] job_weights;
    logic                                            job_valid;
    logic                                            job_ready;
    logic                                            act_load;
    logic [neuron_num-1:0][out_w-1:0]                lay_outputs;
    logic                                            lay_overflow;
    logic                                            lay_valid;
    logic                                            lay_ready;

    assign act_load = job_valid && job_ready;   // layer accepts a job

    job_loader loader_i (
        .clk         (clk),
        .rst         (rst),
        .cfg_curr    (cfg_curr),
        .cfg_prev    (cfg_prev),
        .cfg_act     (cfg_act),
        .cfg_inputs  (cfg_inputs),
        .cfg_valid   (cfg_valid),
        .cfg_ready   (cfg_ready),
        .row_data    (row_data),
        .row_valid   (row_valid),
        .row_ready   (row_ready),
        .job_curr    (job_curr),
        .job_prev    (job_prev),
        .job_act     (act_sel),
        .job_inputs  (job_inputs),
        .job_weights (job_weights),
        .job_valid   (job_valid),
        .job_ready   (job_ready)
    );

    layer layer_i (
        .clk          (clk),
        .rst          (rst),
        .job_curr     (job_curr),
        .job_prev     (job_prev),
        .job_inputs   (job_inputs),
        .job_weights  (job_weights),
        .job_valid    (job_valid),
        .job_ready    (job_ready),
        .lay_outputs  (lay_outputs),
        .lay_overflow (lay_overflow),
        .lay_valid    (lay_valid),
        .lay_ready    (lay_ready)
    );

    activation_out act_i (
        .clk           (clk),
        .rst           (rst),
        .act_sel       (act_sel),
        .act_load      (act_load),
        .lay_outputs   (lay_outputs),
        .lay_overflow  (lay_overflow),
        .lay_valid     (lay_valid),
        .lay_ready     (lay_ready),
        .outputs       (outputs),
        .overflow      (overflow),
        .outputs_valid (outputs_valid),
        .outputs_ready (outputs_ready)
    );

endmodule

`default_nettype wire

// File: sim/nn_layer_sva.sv
`timescale 1ns/1ps
`default_nettype none

module nn_layer_sva (
    input logic                                                                    clk,
    input logic                                                                    rst,
    input logic                                                                    cfg_valid,
    input logic                                                                    cfg_ready,
    input logic [nn_pkg::cnt_w-1:0]                                                cfg_curr,
    input logic [nn_pkg::cnt_w-1:0]                                                cfg_prev,
    input nn_pkg::act_e                                                            cfg_act,
    input logic [nn_pkg::neuron_num-1:0][nn_pkg::out_w-1:0]                        cfg_inputs,
    input logic                                                                    job_valid,
    input logic                                                                    job_ready,
    input logic [nn_pkg::cnt_w-1:0]                                                job_curr,
    input logic [nn_pkg::cnt_w-1:0]                                                job_prev,
    input logic [nn_pkg::neuron_num-1:0][nn_pkg::out_w-1:0]                        job_inputs,
    input logic [nn_pkg::neuron_num-1:0][nn_pkg::neuron_num-1:0][nn_pkg::wgt_w-1:0] job_weights,
    input logic                                                                    lay_valid,
    input logic                                                                    lay_ready,
    input logic [nn_pkg::neuron_num-1:0][nn_pkg::out_w-1:0]                        lay_outputs,
    input logic                                                                    lay_overflow,
    input logic                                                                    outputs_valid,
    input logic                                                                    outputs_ready,
    input logic [nn_pkg::neuron_num-1:0][nn_pkg::out_w-1:0]                        outputs,
    input logic                                                                    overflow,
    input nn_pkg::layer_state_e                                                    lay_state
);

    import nn_pkg::*;

    ////////////////////////////////////////
    // valid holds with stable data
    ////////////////////////////////////////
    cfg_hold: assert property (@(posedge clk) disable iff (rst)
        cfg_valid && !cfg_ready |=> cfg_valid && $stable({cfg_curr, cfg_prev, cfg_act, cfg_inputs}))
        else $error("cfg channel dropped valid or changed data before ready");

    job_hold: assert property (@(posedge clk) disable iff (rst)
        job_valid && !job_ready |=> job_valid && $stable({job_curr, job_prev, job_inputs, job_weights}))
        else $error("job channel dropped valid or changed data before ready");

    lay_hold: assert property (@(posedge clk) disable iff (rst)
        lay_valid && !lay_ready |=> lay_valid && $stable({lay_outputs, lay_overflow}))
        else $error("layer result dropped valid or changed before ready");

    out_hold: assert property (@(posedge clk) disable iff (rst)
        outputs_valid && !outputs_ready |=> outputs_valid && $stable({outputs, overflow}))
        else $error("result port dropped valid or changed before ready");

    // no stale result straight out of reset
    out_reset: assert property (@(posedge clk) rst |=> !outputs_valid)
        else $error("outputs_valid high after reset");

    done_hold: assert property (@(posedge clk) disable iff (rst)
        lay_state == done && !lay_ready |=> lay_state == done)
        else $error("layer left done without lay_ready");

endmodule

bind nn_layer_top nn_layer_sva sva_i (
    .*,
    .lay_state (layer_i.state)
);

`default_nettype wire

// File: sim/tb_nn_layer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_nn_layer;

    import nn_pkg::*;

    localparam int wait_limit = 200;    // cycles per wait

    typedef logic [neuron_num-1:0][out_w-1:0]                 vec_t;
    typedef logic [neuron_num-1:0][neuron_num-1:0][wgt_w-1:0] mat_t;

    logic                             clk;
    logic                             rst;
    logic [cnt_w-1:0]                 cfg_curr;
    logic [cnt_w-1:0]                 cfg_prev;
    act_e                             cfg_act;
    vec_t                             cfg_inputs;
    logic                             cfg_valid;
    logic                             cfg_ready;
    logic [neuron_num-1:0][wgt_w-1:0] row_data;
    logic                             row_valid;
    logic                             row_ready;
    vec_t                             outputs;
    logic                             overflow;
    logic                             outputs_valid;
    logic                             outputs_ready;

    int   errors;
    int   checks;
    int   tests;
    vec_t exp_out_q[$];    // expected results in job order
    logic exp_ovf_q[$];

    nn_layer_top dut_i (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////
    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic probe(input int sel);
        case (sel)
            0:       return cfg_ready;
            1:       return row_ready;
            default: return outputs_valid;
        endcase
    endfunction

    // starts and ends on a falling edge
    task automatic wait_high(input int sel, input string what);
        int n;
        n = 0;
        while (!probe(sel) && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (!probe(sel)) begin
            $display("timeout: %s stayed low for %0d cycles", what, wait_limit);
            $display(">>> FAIL");
            $finish;
        end
    endtask

    function automatic int small_val();
        return int'($urandom % 16) - 8;    // -8..7
    endfunction

    task automatic random_job(output vec_t x, output mat_t w);
        int v;
        for (int k = 0; k < neuron_num; k++) begin
            v    = small_val();
            x[k] = v[out_w-1:0];
            for (int n = 0; n < neuron_num; n++) begin
                v       = small_val();
                w[n][k] = v[wgt_w-1:0];
            end
        end
    endtask

    // reference model of dot product, shift, clip to out_w and activation
    task automatic model(input int curr, input int prev, input act_e act,
                         input vec_t x, input mat_t w, output vec_t y, output logic ovf);
        longint acc;
        longint hi;
        longint lo;
        hi  = 2 ** (out_w - 1) - 1;
        lo  = -hi - 1;
        y   = '0;
        ovf = 1'b0;
        for (int n = 0; n < curr; n++) begin
            acc = 0;
            for (int k = 0; k < prev; k++) begin
                acc += longint'($signed(w[n][k])) * longint'($signed(x[k]));
            end
            acc = acc >>> fraction;
            if (acc > hi) begin
                acc = hi;
                ovf = 1'b1;
            end else if (acc < lo) begin
                acc = lo;
                ovf = 1'b1;
            end
            if (act == act_relu && acc < 0) begin
                acc = 0;
            end
            y[n] = acc[out_w-1:0];
        end
    endtask

    task automatic load_job(input int curr, input int prev, input act_e act,
                            input vec_t x, input mat_t w);
        vec_t y;
        logic ovf;
        model(curr, prev, act, x, w, y, ovf);
        exp_out_q.push_back(y);
        exp_ovf_q.push_back(ovf);
        cfg_curr   = curr[cnt_w-1:0];
        cfg_prev   = prev[cnt_w-1:0];
        cfg_act    = act;
        cfg_inputs = x;
        cfg_valid  = 1'b1;
        wait_high(0, "cfg_ready");
        @(negedge clk);
        cfg_valid = 1'b0;
        for (int r = 0; r < curr; r++) begin
            row_data  = w[r];    // row r feeds neuron r
            row_valid = 1'b1;
            wait_high(1, "row_ready");
            @(negedge clk);
        end
        row_valid = 1'b0;
    endtask

    task automatic collect();
        vec_t y;
        logic ovf;
        wait_high(2, "outputs_valid");
        y   = exp_out_q.pop_front();
        ovf = exp_ovf_q.pop_front();
        check("outputs", outputs, y);
        check("overflow", overflow, ovf);
        outputs_ready = 1'b1;
        @(negedge clk);
        outputs_ready = 1'b0;
    endtask

    task automatic report_test(input string name, input int err0);
        tests++;
        if (errors == err0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d mismatches", name, errors - err0);
        end
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////
    task automatic test_full_linear();
        int   err0;
        vec_t x;
        mat_t w;
        err0 = errors;
        check("cfg_ready after reset", cfg_ready, 1'b1);
        check("row_ready after reset", row_ready, 1'b0);
        check("outputs_valid after reset", outputs_valid, 1'b0);
        random_job(x, w);
        load_job(4, 4, act_linear, x, w);
        collect();
        report_test("full layer linear", err0);
    endtask

    task automatic test_partial();
        int   err0;
        vec_t x;
        mat_t w;
        err0 = errors;
        random_job(x, w);
        x[3]    = 10'd100;    // beyond prev so never counted
        w[0][3] = 16'd50;
        w[1][3] = 16'd50;
        load_job(2, 3, act_linear, x, w);
        collect();
        report_test("partial counts", err0);
    endtask

    task automatic test_relu();
        int   err0;
        vec_t x;
        mat_t w;
        err0 = errors;
        x    = {neuron_num{10'd1}};
        w[0] = {neuron_num{16'd5}};                      // +20
        w[1] = {neuron_num{16'hfffb}};                   // -20
        w[2] = {16'h0000, 16'h0000, 16'hffff, 16'h0003}; // +2
        w[3] = {16'h0000, 16'h0000, 16'h0001, 16'hfffd}; // -2
        load_job(4, 4, act_relu, x, w);
        collect();
        report_test("relu", err0);
    endtask

    task automatic test_saturation();
        int   err0;
        vec_t x;
        mat_t w;
        err0 = errors;
        x    = {neuron_num{10'h1ff}};     // largest input
        w[0] = {neuron_num{16'd1000}};    // clips high
        w[1] = {neuron_num{16'hfc18}};    // clips low
        w[2] = '0;
        w[3] = '0;
        load_job(4, 4, act_linear, x, w);
        collect();
        // a normal job clears the flag again
        random_job(x, w);
        load_job(4, 4, act_linear, x, w);
        collect();
        report_test("saturation", err0);
    endtask

    task automatic test_backpressure();
        int   err0;
        vec_t x;
        mat_t w;
        err0 = errors;
        outputs_ready = 1'b0;
        random_job(x, w);
        load_job(4, 4, act_linear, x, w);
        random_job(x, w);
        load_job(3, 4, act_relu, x, w);
        random_job(x, w);
        load_job(4, 2, act_linear, x, w);
        repeat (20) @(negedge clk);    // pipe full and stalled
        check("cfg_ready under stall", cfg_ready, 1'b0);
        check("row_ready under stall", row_ready, 1'b0);
        check("outputs_valid under stall", outputs_valid, 1'b1);
        check("held outputs", outputs, exp_out_q[0]);
        collect();
        collect();
        collect();
        report_test("back-pressure", err0);
    endtask

    task automatic test_zero_curr();
        int   err0;
        vec_t x;
        mat_t w;
        err0 = errors;
        random_job(x, w);
        load_job(0, 3, act_linear, x, w);
        collect();
        report_test("zero current neurons", err0);
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        void'($urandom(32'hd5f2));
        errors        = 0;
        checks        = 0;
        tests         = 0;
        rst           = 1'b1;
        cfg_curr      = '0;
        cfg_prev      = '0;
        cfg_act       = act_linear;
        cfg_inputs    = '0;
        cfg_valid     = 1'b0;
        row_data      = '0;
        row_valid     = 1'b0;
        outputs_ready = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_full_linear();
        test_partial();
        test_relu();
        test_saturation();
        test_backpressure();
        test_zero_curr();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
hw/nn_pkg.sv
hw/neuron.sv
hw/layer.sv
hw/job_loader.sv
hw/activation_out.sv
hw/nn_layer_top.sv
sim/nn_layer_sva.sv
sim/tb_nn_layer.sv
